// File: include/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath and memory geometry.
`define CPU_DATA_W 8
`define CPU_ADDR_W 8

// location mirrored on the probe port.
`define CPU_PROBE_ADDR 8'h40

`define CPU_START_PC 8'h00

`endif

// File: rtl/cpuPkg.sv
`default_nettype none

`include "cpu_cfg.svh"

package cpuPkg;

	// ####################################################################
	// instruction encoding
	// ####################################################################

	// high nibble of the opcode byte.
	typedef enum logic [3:0] {
		opHalt   = 4'h0,
		opStore  = 4'h1,
		opAluMem = 4'h3,
		opAluImm = 4'h4,
		opBranch = 4'h5
	} opClass_e;

	typedef enum logic [2:0] {
		aluPass = 3'd0,
		aluAdd  = 3'd1,
		aluSub  = 3'd2,
		aluAnd  = 3'd3,
		aluOr   = 3'd4,
		aluXor  = 3'd5
	} aluOp_e;

	typedef struct packed {
		opClass_e cls;
		logic     spare;
		aluOp_e   op;
	} aluForm_s;

	// cond 0 always, 1 zero, 2 carry, 3 never.
	typedef struct packed {
		opClass_e   cls;
		logic       spare;
		logic       inv;      // negates the test.
		logic [1:0] cond;
	} branchForm_s;

	// the same opcode byte, seen by the alu or by the branch logic.
	typedef union packed {
		aluForm_s    alu;
		branchForm_s br;
	} instrWord_u;

	typedef struct packed {
		logic zero;
		logic carry;
	} flags_s;

	// ####################################################################
	// buses
	// ####################################################################

	typedef struct packed {
		logic [`CPU_ADDR_W-1:0] addr;
		logic [`CPU_DATA_W-1:0] wdata;
		logic                   we;
	} memReq_s;

	// wishbone classic, master to slave.
	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic [`CPU_ADDR_W-1:0] adr;
		logic [`CPU_DATA_W-1:0] dat;
	} wbReq_s;

	typedef struct packed {
		logic                   ack;
		logic [`CPU_DATA_W-1:0] dat;
	} wbRsp_s;

endpackage

`default_nettype wire

// File: rtl/cpuMemory.sv
`default_nettype none

`include "cpu_cfg.svh"

module cpuMemory (
	input  wire                    clk,
	input  wire                    nRst,
	input  cpuPkg::memReq_s        req,
	output logic [`CPU_DATA_W-1:0] rdata,
	output logic [`CPU_DATA_W-1:0] probe
);

	localparam int Depth = 1 << `CPU_ADDR_W;

	logic [`CPU_DATA_W-1:0] mem [Depth];

	assign rdata = mem[req.addr];   // asynchronous read.
	assign probe = mem[`CPU_PROBE_ADDR];

	// whole array clears on reset, no program image.
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < Depth; i++) begin
				mem[i] <= '0;
			end
		end else if (req.we) begin
			mem[req.addr] <= req.wdata;
		end
	end

endmodule

`default_nettype wire

// File: rtl/aluUnit.sv
`default_nettype none

`include "cpu_cfg.svh"

module aluUnit (
	input  wire                    clk,
	input  wire                    nRst,
	input  logic                   exec,
	input  cpuPkg::instrWord_u     instr,
	input  logic [`CPU_DATA_W-1:0] operand,
	input  logic [`CPU_DATA_W-1:0] memData,
	output logic [`CPU_DATA_W-1:0] acc,
	output cpuPkg::flags_s         flags
);

	logic                   isAlu;
	logic [`CPU_DATA_W-1:0] b;
	logic [`CPU_DATA_W:0]   wide;   // result with carry or borrow on top.
	logic [`CPU_DATA_W-1:0] res;
	logic                   carryNext;

	assign isAlu = (instr.alu.cls == cpuPkg::opAluMem) || (instr.alu.cls == cpuPkg::opAluImm);
	assign b = (instr.alu.cls == cpuPkg::opAluImm) ? operand : memData;

	always_comb begin
		wide = {1'b0, b};   // pass, also for the unused codes.
		case (instr.alu.op)
			cpuPkg::aluAdd: wide = {1'b0, acc} + {1'b0, b};
			cpuPkg::aluSub: wide = {1'b0, acc} - {1'b0, b};   // msb is the borrow.
			cpuPkg::aluAnd: wide = {1'b0, acc & b};
			cpuPkg::aluOr:  wide = {1'b0, acc | b};
			cpuPkg::aluXor: wide = {1'b0, acc ^ b};
			default:        wide = {1'b0, b};
		endcase
		res = wide[`CPU_DATA_W-1:0];
		carryNext = wide[`CPU_DATA_W];
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			acc <= '0;
			flags <= '0;
		end else if (exec && isAlu) begin
			acc <= res;
			flags.zero <= (res == '0);
			flags.carry <= carryNext;   // zero for the logic ops.
		end
	end

endmodule

`default_nettype wire

// File: rtl/programCounter.sv
`default_nettype none

`include "cpu_cfg.svh"

module programCounter (
	input  wire                    clk,
	input  wire                    nRst,
	input  logic                   inc,
	input  logic                   load,
	input  logic                   clear,
	input  logic                   retire,
	input  logic [`CPU_ADDR_W-1:0] target,
	output logic [`CPU_ADDR_W-1:0] pc,
	output logic [7:0]             retired
);

	// clear wins over load, load over increment.
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			pc <= '0;
		end else if (clear) begin
			pc <= `CPU_START_PC;
		end else if (load) begin
			pc <= target;
		end else if (inc) begin
			pc <= pc + 1'b1;
		end
	end

	// instructions retired since start, wraps at 256.
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			retired <= '0;
		end else if (clear) begin
			retired <= '0;
		end else if (retire) begin
			retired <= retired + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/cpuControl.sv
`default_nettype none

`include "cpu_cfg.svh"

module cpuControl (
	input  wire                    clk,
	input  wire                    nRst,
	input  logic                   start,
	input  cpuPkg::memReq_s        hostReq,
	output cpuPkg::memReq_s        memReq,
	input  logic [`CPU_DATA_W-1:0] rdata,
	input  logic [`CPU_ADDR_W-1:0] pc,
	input  cpuPkg::flags_s         flags,
	output logic                   pcInc,
	output logic                   pcLoad,
	output logic                   pcClear,
	output logic                   retire,
	output logic [`CPU_ADDR_W-1:0] pcTarget,
	output logic                   exec,
	output cpuPkg::instrWord_u     instr,
	output logic [`CPU_DATA_W-1:0] operand,
	input  logic [`CPU_DATA_W-1:0] acc,
	output logic                   busy,
	output logic                   halted
);

	typedef enum logic [2:0] {
		stIdle,
		stFetch,
		stOperand,
		stExecute,
		stHalted
	} state_e;

	state_e                 state;
	state_e                 stateNext;
	cpuPkg::instrWord_u     instrReg;
	logic [`CPU_DATA_W-1:0] operandReg;
	logic                   running;
	logic                   testBit;
	logic                   taken;
	logic                   isHalt;

	assign running = (state == stFetch) || (state == stOperand) || (state == stExecute);
	assign busy = running;
	assign halted = (state == stHalted);

	// ####################################################################
	// decode
	// ####################################################################

	always_comb begin
		case (instrReg.br.cond)
			2'd0:    testBit = 1'b1;
			2'd1:    testBit = flags.zero;
			2'd2:    testBit = flags.carry;
			default: testBit = 1'b0;   // never.
		endcase
	end

	assign taken = (instrReg.br.cls == cpuPkg::opBranch) && (testBit ^ instrReg.br.inv);

	// unknown classes stop the machine like hlt.
	always_comb begin
		case (instrReg.alu.cls)
			cpuPkg::opStore, cpuPkg::opAluMem, cpuPkg::opAluImm, cpuPkg::opBranch:
				isHalt = 1'b0;
			default:
				isHalt = 1'b1;
		endcase
	end

	// ####################################################################
	// state machine
	// ####################################################################

	always_comb begin
		stateNext = state;
		case (state)
			stFetch:   stateNext = stOperand;
			stOperand: stateNext = stExecute;
			stExecute: stateNext = isHalt ? stHalted : stFetch;
			default:   stateNext = start ? stFetch : state;   // idle or halted.
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= stIdle;
		end else begin
			state <= stateNext;
		end
	end

	always_ff @(posedge clk) begin
		if (state == stFetch) begin
			instrReg <= rdata;
		end
		if (state == stOperand) begin
			operandReg <= rdata;
		end
	end

	assign pcClear = start && !running;
	assign pcInc = (state == stFetch) || (state == stOperand);
	assign pcLoad = (state == stExecute) && taken;
	assign pcTarget = operandReg;
	assign exec = (state == stExecute);
	assign retire = (state == stExecute);   // hlt counts too.
	assign instr = instrReg;
	assign operand = operandReg;

	// memory port: host when stopped, else pc or operand address.
	always_comb begin
		memReq = hostReq;
		if (running) begin
			memReq.addr = pc;
			memReq.wdata = acc;
			memReq.we = 1'b0;
			if (state == stExecute) begin
				memReq.addr = operandReg;
				memReq.we = (instrReg.alu.cls == cpuPkg::opStore);
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/hostBridge.sv
`default_nettype none

`include "cpu_cfg.svh"

module hostBridge (
	input  wire                    clk,
	input  wire                    nRst,
	input  cpuPkg::wbReq_s         wbReq,
	output cpuPkg::wbRsp_s         wbRsp,
	input  logic                   busy,
	output cpuPkg::memReq_s        hostReq,
	input  logic [`CPU_DATA_W-1:0] rdata
);

	logic                   ackReg;
	logic [`CPU_DATA_W-1:0] datReg;
	logic                   hit;

	// one ack per cycle, held off while the core owns memory.
	assign hit = wbReq.cyc && wbReq.stb && !busy && !ackReg;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			ackReg <= 1'b0;
		end else begin
			ackReg <= hit;
		end
	end

	always_ff @(posedge clk) begin
		if (hit) begin
			datReg <= rdata;   // valid while ack is high.
		end
	end

	assign hostReq.addr = wbReq.adr;
	assign hostReq.wdata = wbReq.dat;
	assign hostReq.we = hit && wbReq.we;   // lands on the edge that raises ack.

	assign wbRsp.ack = ackReg;
	assign wbRsp.dat = datReg;

endmodule

`default_nettype wire

// File: rtl/cpuTop.sv
`default_nettype none

`include "cpu_cfg.svh"

module cpuTop (
	input  wire                    clk,
	input  wire                    nRst,
	input  logic                   start,
	input  cpuPkg::wbReq_s         wbReq,
	output cpuPkg::wbRsp_s         wbRsp,
	output logic                   busy,
	output logic                   halted,
	output logic [`CPU_DATA_W-1:0] probe,
	output logic [7:0]             retired
);

	cpuPkg::memReq_s        hostReq;
	cpuPkg::memReq_s        memReq;
	logic [`CPU_DATA_W-1:0] rdata;
	logic [`CPU_ADDR_W-1:0] pc;
	logic [`CPU_ADDR_W-1:0] pcTarget;
	cpuPkg::flags_s         flags;
	logic                   pcInc;
	logic                   pcLoad;
	logic                   pcClear;
	logic                   retire;
	logic                   exec;
	cpuPkg::instrWord_u     instr;
	logic [`CPU_DATA_W-1:0] operand;
	logic [`CPU_DATA_W-1:0] acc;

	hostBridge hostBridge_i (
		.clk(clk), .nRst(nRst),
		.wbReq(wbReq), .wbRsp(wbRsp),
		.busy(busy), .hostReq(hostReq), .rdata(rdata)
	);

	cpuControl cpuControl_i (
		.clk(clk), .nRst(nRst), .start(start),
		.hostReq(hostReq), .memReq(memReq), .rdata(rdata),
		.pc(pc), .flags(flags),
		.pcInc(pcInc), .pcLoad(pcLoad), .pcClear(pcClear), .retire(retire),
		.pcTarget(pcTarget), .exec(exec), .instr(instr), .operand(operand),
		.acc(acc), .busy(busy), .halted(halted)
	);

	programCounter programCounter_i (
		.clk(clk), .nRst(nRst),
		.inc(pcInc), .load(pcLoad), .clear(pcClear), .retire(retire),
		.target(pcTarget), .pc(pc), .retired(retired)
	);

	// memData is the read port, addressed by the operand in execute.
	aluUnit aluUnit_i (
		.clk(clk), .nRst(nRst),
		.exec(exec), .instr(instr), .operand(operand), .memData(rdata),
		.acc(acc), .flags(flags)
	);

	cpuMemory cpuMemory_i (
		.clk(clk), .nRst(nRst),
		.req(memReq), .rdata(rdata), .probe(probe)
	);

endmodule

`default_nettype wire

// File: test/cpuTop_checker.sv
`default_nettype none

module cpuTop_checker (
	input wire            clk,
	input wire            nRst,
	input cpuPkg::wbRsp_s wbRsp,
	input logic           busy,
	input logic           halted
);
	timeunit 1ns;
	timeprecision 100ps;

	// ####################################################################
	// host port handshake
	// ####################################################################

	ackOneCycle: assert property (@(posedge clk) disable iff (!nRst)
		wbRsp.ack |=> !wbRsp.ack)
		else $error("ack stayed high for more than one cycle");

	ackNotWhileBusy: assert property (@(posedge clk) disable iff (!nRst)
		$rose(wbRsp.ack) |-> !busy)
		else $error("ack rose while the core was busy");

	// ####################################################################
	// run state
	// ####################################################################

	// a run only ends by entering halt.
	busyEndsInHalt: assert property (@(posedge clk) disable iff (!nRst)
		$fell(busy) |-> halted)
		else $error("busy fell without the core entering halt");

	// first edge out of reset.
	haltedLowAfterReset: assert property (@(posedge clk)
		!$past(nRst) |-> !halted)
		else $error("halted high right after reset");

endmodule

bind cpuTop cpuTop_checker cpuTop_checker_i (
	.clk(clk), .nRst(nRst), .wbRsp(wbRsp), .busy(busy), .halted(halted)
);

`default_nettype wire

// File: test/cpuTb.sv
`default_nettype none

`include "cpu_cfg.svh"

module cpuTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int AckTimeout = 20;     // cycles, host access while stopped.
	localparam int RunTimeout = 5000;   // cycles, longest program in the file.

	logic                   clk;
	logic                   nRst;
	logic                   start;
	cpuPkg::wbReq_s         wbReq;
	cpuPkg::wbRsp_s         wbRsp;
	logic                   busy;
	logic                   halted;
	logic [`CPU_DATA_W-1:0] probe;
	logic [7:0]             retired;
	logic                   haltedAtAck;

	cpuTop cpuTop_i (
		.clk(clk), .nRst(nRst), .start(start),
		.wbReq(wbReq), .wbRsp(wbRsp),
		.busy(busy), .halted(halted), .probe(probe), .retired(retired)
	);

	always #4 clk = ~clk;

	// ####################################################################
	// checking
	// ####################################################################

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [7:0] actual,
			input logic [7:0] expected);
		if (actual !== expected) begin
			failRun($sformatf("ERROR at %0d ns: %s is %02h, expected %02h",
				$time, name, actual, expected));
		end
	endtask

	// ####################################################################
	// host port and run control
	// ####################################################################

	// sampled on the falling edge, away from the DUT's updates.
	task automatic waitAck(input int limit, output logic [7:0] data);
		int n;
		n = 0;
		@(negedge clk);
		while (wbRsp.ack !== 1'b1) begin
			if (n == limit) begin
				failRun("timeout: the DUT never acknowledged the host access");
			end
			@(negedge clk);
			n++;
		end
		data = wbRsp.dat;
		haltedAtAck = halted;
	endtask

	task automatic hostAccess(input logic we, input logic [7:0] addr,
			input logic [7:0] data, input int limit, output logic [7:0] rdat);
		@(posedge clk);
		wbReq.cyc <= 1'b1;
		wbReq.stb <= 1'b1;
		wbReq.we <= we;
		wbReq.adr <= addr;
		wbReq.dat <= data;
		waitAck(limit, rdat);
		@(posedge clk);
		wbReq.cyc <= 1'b0;
		wbReq.stb <= 1'b0;
		wbReq.we <= 1'b0;
	endtask

	task automatic pulseStart();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic waitStopped();
		int n;
		n = 0;
		@(negedge clk);
		while (halted !== 1'b1) begin
			if (n == RunTimeout) begin
				failRun("timeout: the program never reached halt");
			end
			@(negedge clk);
			n++;
		end
		n = 0;
		while (busy !== 1'b0) begin
			if (n == AckTimeout) begin
				failRun("timeout: busy stayed high after halt");
			end
			@(negedge clk);
			n++;
		end
	endtask

	// ####################################################################
	// test file
	// ####################################################################

	initial begin
		int         fd;
		string      line;
		byte        cmd;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		logic [7:0] got;

		clk = 1'b0;
		nRst = 1'b0;
		start = 1'b0;
		wbReq = '0;
		haltedAtAck = 1'b0;
		repeat (4) @(posedge clk);
		nRst <= 1'b1;

		fd = $fopen("test/cpu_tests.txt", "r");
		if (fd == 0) begin
			failRun("could not open test/cpu_tests.txt");
		end

		while ($fgets(line, fd) != 0) begin
			cmd = line.getc(0);
			a = 8'h00;
			b = 8'h00;
			c = 8'h00;
			void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
			case (cmd)
				"W": hostAccess(1'b1, a, b, AckTimeout, got);
				"I": begin   // opcode byte, then operand byte.
					hostAccess(1'b1, a, b, AckTimeout, got);
					hostAccess(1'b1, a + 8'd1, c, AckTimeout, got);
				end
				"R": begin
					hostAccess(1'b0, a, 8'h00, AckTimeout, got);
					checkValue($sformatf("mem[%02h]", a), got, b);
				end
				"G": begin
					pulseStart();
					@(negedge clk);
					checkValue("busy", {7'd0, busy}, 8'h01);
					checkValue("halted", {7'd0, halted}, 8'h00);
					waitStopped();
				end
				"B": begin
					pulseStart();
					@(negedge clk);
					checkValue("busy", {7'd0, busy}, 8'h01);
					hostAccess(1'b0, a, 8'h00, RunTimeout, got);   // held off until halt.
					checkValue("halted at ack", {7'd0, haltedAtAck}, 8'h01);
					checkValue($sformatf("mem[%02h]", a), got, b);
				end
				"P": begin
					@(negedge clk);
					checkValue("probe", probe, a);
				end
				"N": begin
					@(negedge clk);
					checkValue("retired", retired, a);
				end
				"#", "\n", "\r", " ": ;
				default: failRun($sformatf("unknown command in test file: %s", line));
			endcase
		end
		$fclose(fd);

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
rtl/cpuPkg.sv
rtl/cpuMemory.sv
rtl/aluUnit.sv
rtl/programCounter.sv
rtl/cpuControl.sv
rtl/hostBridge.sv
rtl/cpuTop.sv
test/cpuTop_checker.sv
test/cpuTb.sv

// File: Makefile
SRC := $(filter-out +incdir+%,$(shell cat verilog.f)) include/cpu_cfg.svh

.PHONY: all run clean

all: run

obj_dir/VcpuTb: verilog.f $(SRC)
	verilator --binary --timing --assert --top-module cpuTb -Mdir obj_dir -f verilog.f

run: obj_dir/VcpuTb
	./obj_dir/VcpuTb > sim.log 2>&1; cat sim.log
	@! grep -q "Verification failed" sim.log && grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/cpu_tests.txt
# W addr data | I addr opcode operand | R addr expected | P probe | N retired
# G runs to halt | B addr expected reads while a program runs; all values hex
# host access after reset
R 00 00
R 40 00
R ff 00
W 10 a5
R 10 a5
W ff 81
R ff 81
W 40 3c
P 3c
R 40 3c
# arithmetic and flags, results stored at 90..94 and 40
W 80 37
W 81 c9
I 00 40 f0
I 02 41 25
I 04 10 90
I 06 31 80
I 08 10 91
I 0a 32 81
I 0c 10 92
I 0e 43 0f
I 10 10 93
I 12 34 80
I 14 10 94
I 16 45 ff
I 18 10 40
I 1a 00 00
G
R 90 15
R 91 4c
R 92 83
R 93 03
R 94 37
P c8
N 0e
# branches: count down 5 with jnz, then jc, jnc and a never branch
W a1 00
W a2 00
I 00 40 05
I 02 10 a0
I 04 30 a1
I 06 41 01
I 08 10 a1
I 0a 30 a0
I 0c 42 01
I 0e 10 a0
I 10 55 04
I 12 40 ff
I 14 41 02
I 16 52 1c
I 18 40 ee
I 1a 10 a2
I 1c 40 c3
I 1e 10 a3
I 20 56 24
I 22 00 00
I 24 53 00
I 26 40 7e
I 28 10 a4
I 2a 00 00
G
R a0 00
R a1 05
R a2 00
R a3 c3
R a4 7e
N 2f
P c8
# unknown opcode class stops like hlt
I 00 70 00
G
N 01
# back-pressure, 150 loop passes, 305 instructions wrap to 31
I 00 40 96
I 02 42 01
I 04 55 02
I 06 10 b0
I 08 40 5a
I 0a 10 40
I 0c 00 00
W b0 ff
B 40 5a
N 31
P 5a
R b0 00
